//--- source/matvec_mul.sv
`timescale 1ns/1ps
`default_nettype none

module matvec_mul (
    input  logic            clk,
    input  logic            rstn,
    input  logic            i_start,
    input  vtx_pkg::coord_t i_matrix [4][4],
    input  vtx_pkg::coord_t i_vector [4],
    output logic            o_busy,
    output vtx_pkg::coord_t o_result [4],
    output logic            o_done
);

    import vtx_pkg::*;

    coord_t     mat_r [4][4];
    coord_t     vec_r [4];
    logic [1:0] row;                            // row under computation
    logic       start_ok;
    prod_t      prod [4];
    acc_t       acc;
    acc_t       acc_sh;
    coord_t     row_val;

    assign start_ok = i_start && !o_busy;

    // operands stay put for all four row cycles
    always_ff @(posedge clk) begin
        if (start_ok) begin
            mat_r <= i_matrix;
            vec_r <= i_vector;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // row datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        acc = '0;
        for (int k = 0; k < 4; k++) begin
            prod[k] = mat_r[row][k] * vec_r[k];
            acc     = acc + acc_t'(prod[k]);    // sign extend, exact
        end
        acc_sh  = acc >>> FRAC_W;               // floor
        row_val = coord_t'(acc_sh);             // wrap to coordinate width
    end

    always_ff @(posedge clk) begin
        if (o_busy) begin
            o_result[row] <= row_val;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // start in cycle s, rows in s+1..s+4, done in s+5
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_busy <= 1'b0;
            o_done <= 1'b0;
            row    <= '0;
        end else begin
            o_done <= 1'b0;
            if (start_ok) begin
                o_busy <= 1'b1;
                row    <= '0;
            end else if (o_busy) begin
                row <= row + 1'b1;
                if (row == 2'd3) begin
                    o_busy <= 1'b0;             // last row written this edge
                    o_done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/vertex_in_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_in_buffer (
    input  logic            clk,
    input  logic            rstn,
    input  logic            i_push,
    input  vtx_pkg::coord_t i_vertex [3],
    input  logic            i_last,
    input  logic            i_pop,
    output logic            o_valid,
    output vtx_pkg::coord_t o_vertex [3],
    output logic            o_last,
    output logic            o_credit
);

    import vtx_pkg::*;

    coord_t                      slot_xyz  [IN_DEPTH][3];
    logic                        slot_last [IN_DEPTH];
    logic [$clog2(IN_DEPTH)-1:0] wr_ptr;
    logic [$clog2(IN_DEPTH)-1:0] rd_ptr;
    logic [CREDIT_W-1:0]         count;
    logic                        pop;

    assign pop = i_pop && o_valid;              // never pop an empty buffer

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (i_push) begin
            slot_xyz[wr_ptr]  <= i_vertex;
            slot_last[wr_ptr] <= i_last;
        end
    end

    assign o_vertex = slot_xyz[rd_ptr];         // head of queue
    assign o_last   = slot_last[rd_ptr];
    assign o_valid  = (count != '0);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pointers and credit return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // upstream only pushes with a credit, so a full buffer is never pushed
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == IN_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == IN_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end

            case ({i_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                      // both or neither
            endcase

            o_credit <= pop;                    // one slot freed
        end
    end

endmodule

`default_nettype wire

//--- source/vertex_shader.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_shader (
    input  logic            clk,
    input  logic            rstn,
    input  vtx_pkg::coord_t i_mvp [4][4],
    input  logic            i_mvp_valid,
    input  logic            i_buf_valid,
    input  vtx_pkg::coord_t i_buf_vertex [3],
    input  logic            i_buf_last,
    input  logic            i_mv_busy,
    input  vtx_pkg::coord_t i_mv_result [4],
    input  logic            i_mv_done,
    input  logic            i_out_credit,
    output logic            o_mvp_ready,
    output logic            o_buf_pop,
    output logic            o_mv_start,
    output vtx_pkg::coord_t o_mv_matrix [4][4],
    output vtx_pkg::coord_t o_mv_vector [4],
    output vtx_pkg::coord_t o_vertex [4],
    output logic            o_vertex_valid,
    output logic            o_finished
);

    import vtx_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        WAIT_MUL,
        HOLD,
        FINISHED
    } state_t;

    state_t              state;
    state_t              state_nxt;
    coord_t              mvp_r [4][4];
    logic                last_r;            // current vertex closes the batch
    logic [CREDIT_W-1:0] credits;           // free downstream slots
    logic                has_credit;
    logic                take_mvp;
    logic                fetch;
    logic                emit;

    assign has_credit = (credits != '0);
    assign take_mvp   = (state == IDLE) && i_mvp_valid;
    assign fetch      = (state == FETCH) && i_buf_valid && !i_mv_busy;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_nxt = state;
        emit      = 1'b0;

        case (state)
            IDLE: begin
                if (i_mvp_valid) begin
                    state_nxt = FETCH;
                end
            end

            FETCH: begin
                if (fetch) begin
                    state_nxt = WAIT_MUL;
                end
            end

            WAIT_MUL: begin
                if (i_mv_done) begin
                    if (has_credit) begin
                        emit      = 1'b1;
                        state_nxt = last_r ? FINISHED : FETCH;
                    end else begin
                        state_nxt = HOLD;       // receiver full
                    end
                end
            end

            HOLD: begin
                if (has_credit) begin
                    emit      = 1'b1;
                    state_nxt = last_r ? FINISHED : FETCH;
                end
            end

            FINISHED: begin
                state_nxt = IDLE;
            end

            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state          <= IDLE;
            last_r         <= 1'b0;
            credits        <= CREDIT_W'(OUT_CREDITS);
            o_vertex_valid <= 1'b0;
            o_finished     <= 1'b0;
        end else begin
            state          <= state_nxt;
            o_vertex_valid <= emit;             // one cycle after the decision
            o_finished     <= (state == FINISHED);

            if (fetch) begin
                last_r <= i_buf_last;
            end

            case ({i_out_credit, emit})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: ;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (take_mvp) begin
            mvp_r <= i_mvp;
        end
        if ((state == WAIT_MUL) && i_mv_done) begin
            o_vertex <= i_mv_result;            // held through HOLD
        end
    end

    assign o_mvp_ready = (state == IDLE);
    assign o_buf_pop   = fetch;
    assign o_mv_start  = fetch;                 // pop and start together
    assign o_mv_matrix = mvp_r;

    assign o_mv_vector[0] = i_buf_vertex[0];
    assign o_mv_vector[1] = i_buf_vertex[1];
    assign o_mv_vector[2] = i_buf_vertex[2];
    assign o_mv_vector[3] = FIXED_ONE;          // homogeneous w

endmodule

`default_nettype wire

//--- source/vertex_xform_top.sv
`timescale 1ns/1ps
`default_nettype none

module vertex_xform_top (
    input  logic            clk,
    input  logic            rstn,
    input  vtx_pkg::coord_t i_mvp [4][4],
    input  logic            i_mvp_valid,
    output logic            o_mvp_ready,
    input  vtx_pkg::coord_t i_vertex [3],
    input  logic            i_vertex_last,
    input  logic            i_vertex_valid,
    output logic            o_in_credit,
    output vtx_pkg::coord_t o_vertex [4],
    output logic            o_vertex_valid,
    output logic            o_finished,
    input  logic            i_out_credit
);

    import vtx_pkg::*;

    // buffer to shader
    logic   buf_valid;
    coord_t buf_vertex [3];
    logic   buf_last;
    logic   buf_pop;

    // shader to multiplier
    logic   mv_start;
    coord_t mv_matrix [4][4];
    coord_t mv_vector [4];
    logic   mv_busy;
    coord_t mv_result [4];
    logic   mv_done;

    vertex_in_buffer u_in_buf (
        .clk      (clk),
        .rstn     (rstn),
        .i_push   (i_vertex_valid),             // valid already spent a credit
        .i_vertex (i_vertex),
        .i_last   (i_vertex_last),
        .i_pop    (buf_pop),
        .o_valid  (buf_valid),
        .o_vertex (buf_vertex),
        .o_last   (buf_last),
        .o_credit (o_in_credit)
    );

    vertex_shader u_shader (
        .clk            (clk),
        .rstn           (rstn),
        .i_mvp          (i_mvp),
        .i_mvp_valid    (i_mvp_valid),
        .i_buf_valid    (buf_valid),
        .i_buf_vertex   (buf_vertex),
        .i_buf_last     (buf_last),
        .i_mv_busy      (mv_busy),
        .i_mv_result    (mv_result),
        .i_mv_done      (mv_done),
        .i_out_credit   (i_out_credit),
        .o_mvp_ready    (o_mvp_ready),
        .o_buf_pop      (buf_pop),
        .o_mv_start     (mv_start),
        .o_mv_matrix    (mv_matrix),
        .o_mv_vector    (mv_vector),
        .o_vertex       (o_vertex),
        .o_vertex_valid (o_vertex_valid),
        .o_finished     (o_finished)
    );

    matvec_mul u_matvec (
        .clk      (clk),
        .rstn     (rstn),
        .i_start  (mv_start),
        .i_matrix (mv_matrix),
        .i_vector (mv_vector),
        .o_busy   (mv_busy),
        .o_result (mv_result),
        .o_done   (mv_done)
    );

endmodule

`default_nettype wire

//--- source/vtx_pkg.sv
`default_nettype none

package vtx_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fixed-point format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int COORD_W = 24;                // one coordinate
    localparam int FRAC_W  = 13;                // fraction bits

    typedef logic signed [COORD_W-1:0]   coord_t;
    typedef logic signed [2*COORD_W-1:0] prod_t;    // one element product
    typedef logic signed [2*COORD_W+1:0] acc_t;     // four products, no overflow

    localparam coord_t FIXED_ONE = coord_t'(1) << FRAC_W;  // w component

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // flow control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int IN_DEPTH    = 4;             // input slots = upstream credits
    localparam int OUT_CREDITS = 2;             // downstream receiver slots

    // counters must reach the full value, hence the +1
    localparam int CREDIT_MAX = (IN_DEPTH > OUT_CREDITS) ? IN_DEPTH : OUT_CREDITS;
    localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);

endpackage

`default_nettype wire

//--- tests/tb_vertex_xform_model.svh
`ifndef TB_VERTEX_XFORM_MODEL_SVH
`define TB_VERTEX_XFORM_MODEL_SVH

// matrix of the batch under test, row-major
coord_t ref_mvp [4][4];

// expected outputs in input order, x in the low bits
logic [4*COORD_W-1:0] exp_q [$];

// direct results for known matrices, top bit marks a valid entry
logic [4*COORD_W:0] direct_q [$];

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference transform
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

function automatic logic [4*COORD_W-1:0] transform_vertex(input coord_t x,
                                                          input coord_t y,
                                                          input coord_t z);
    longint               vec [4];
    longint               sum;
    logic [4*COORD_W-1:0] res;
    vec[0] = longint'(x);
    vec[1] = longint'(y);
    vec[2] = longint'(z);
    vec[3] = longint'(1) <<< FRAC_W;            // w is 1.0
    for (int r = 0; r < 4; r++) begin
        sum = 0;
        for (int k = 0; k < 4; k++) begin
            sum = sum + longint'(ref_mvp[r][k]) * vec[k];
        end
        sum = sum >>> FRAC_W;                   // floor, negatives too
        res[r*COORD_W +: COORD_W] = sum[COORD_W-1:0];
    end
    return res;
endfunction

// identity plus offsets in the last column
task automatic set_translation(input coord_t tx, input coord_t ty, input coord_t tz);
    for (int r = 0; r < 4; r++) begin
        for (int k = 0; k < 4; k++) begin
            ref_mvp[r][k] = (r == k) ? FIXED_ONE : coord_t'(0);
        end
    end
    ref_mvp[0][3] = tx;
    ref_mvp[1][3] = ty;
    ref_mvp[2][3] = tz;
endtask

`endif

//--- tests/tb_vertex_xform.sv
`timescale 1ns/1ps
`default_nettype none

module tb_vertex_xform;

    import vtx_pkg::*;

    localparam int BATCHES   = 5;
    localparam int TOTAL_VTX = 6 + 6 + 3 * 12;
    localparam int WD_CYCLES = TOTAL_VTX * 40 + 1000;

    logic   clk = 1'b0;
    logic   rstn;
    coord_t i_mvp [4][4];
    logic   i_mvp_valid;
    logic   o_mvp_ready;
    coord_t i_vertex [3];
    logic   i_vertex_last;
    logic   i_vertex_valid;
    logic   o_in_credit;
    coord_t o_vertex [4];
    logic   o_vertex_valid;
    logic   o_finished;
    logic   i_out_credit = 1'b0;

    int     chk_err = 0;
    int     other_err = 0;
    int     sent_cnt = 0;       // vertices pushed upstream
    int     in_ret_cnt = 0;     // o_in_credit pulses seen
    int     out_cnt = 0;        // vertices received downstream
    int     returned_cnt = 0;   // credits handed back to the DUT
    int     fin_cnt = 0;
    int     out_in_batch = 0;
    int     batch_len = 0;
    int     stall_left = 0;
    logic   fin_due = 1'b0;
    logic   stall_en;
    logic   known_batch;
    coord_t trans [3];

    `include "tb_vertex_xform_model.svh"

    vertex_xform_top i_dut (
        .clk            (clk),
        .rstn           (rstn),
        .i_mvp          (i_mvp),
        .i_mvp_valid    (i_mvp_valid),
        .o_mvp_ready    (o_mvp_ready),
        .i_vertex       (i_vertex),
        .i_vertex_last  (i_vertex_last),
        .i_vertex_valid (i_vertex_valid),
        .o_in_credit    (o_in_credit),
        .o_vertex       (o_vertex),
        .o_vertex_valid (o_vertex_valid),
        .o_finished     (o_finished),
        .i_out_credit   (i_out_credit)
    );

    always #4 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [4*COORD_W-1:0] exp_v,
                                   input logic [4*COORD_W-1:0] got_v);
        chk_err++;
        $display("CHECK FAILED t=%0t %s expected %0h got %0h", $time, name, exp_v, got_v);
    endtask

    // signed value spread over the given number of bits
    function automatic coord_t rand_coord(input int bits);
        logic [31:0] r;
        r = $urandom;
        return coord_t'($signed(r) >>> (32 - bits));
    endfunction

    task automatic check_idle_outputs();
        assert (o_vertex_valid == 1'b0) else report_mismatch("o_vertex_valid", 0, o_vertex_valid);
        assert (o_finished == 1'b0) else report_mismatch("o_finished", 0, o_finished);
        assert (o_in_credit == 1'b0) else report_mismatch("o_in_credit", 0, o_in_credit);
        assert (o_mvp_ready == 1'b1) else report_mismatch("o_mvp_ready", 1, o_mvp_ready);
    endtask

    task automatic load_matrix();
        do @(negedge clk); while (!o_mvp_ready);
        @(posedge clk);
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++) begin
                i_mvp[r][k] <= ref_mvp[r][k];
            end
        end
        i_mvp_valid <= 1'b1;
        @(posedge clk);
        i_mvp_valid <= 1'b0;
    endtask

    task automatic send_vertex(input coord_t x, input coord_t y, input coord_t z,
                               input logic last);
        @(posedge clk);
        // wait for a credit plus random idle gaps
        while ((IN_DEPTH - sent_cnt + in_ret_cnt == 0) || ($urandom % 4 == 0)) begin
            i_vertex_valid <= 1'b0;
            @(posedge clk);
        end
        i_vertex[0]    <= x;
        i_vertex[1]    <= y;
        i_vertex[2]    <= z;
        i_vertex_last  <= last;
        i_vertex_valid <= 1'b1;
        sent_cnt++;
        exp_q.push_back(transform_vertex(x, y, z));
        direct_q.push_back({known_batch, FIXED_ONE, coord_t'(z + trans[2]),
                            coord_t'(y + trans[1]), coord_t'(x + trans[0])});
    endtask

    // kind 0 identity, 1 translation, 2 random, 3 random full range
    task automatic run_batch(input int kind, input int n);
        coord_t x;
        coord_t y;
        coord_t z;
        int     bits;
        int     fin_before;
        known_batch = (kind < 2);
        stall_en    = (kind >= 2);
        bits        = (kind == 3) ? 24 : 20;
        trans[0]    = (kind == 1) ? coord_t'(28672) : coord_t'(0);    // 3.5
        trans[1]    = (kind == 1) ? coord_t'(-18432) : coord_t'(0);   // -2.25
        trans[2]    = (kind == 1) ? coord_t'(81920) : coord_t'(0);    // 10.0
        if (known_batch) begin
            set_translation(trans[0], trans[1], trans[2]);
        end else begin
            for (int r = 0; r < 4; r++) begin
                for (int k = 0; k < 4; k++) begin
                    ref_mvp[r][k] = rand_coord((kind == 3) ? 24 : 16);
                end
            end
        end
        batch_len  = n;
        fin_before = fin_cnt;
        load_matrix();
        for (int v = 0; v < n; v++) begin
            x = rand_coord(bits);
            y = rand_coord(bits);
            z = rand_coord(bits);
            send_vertex(x, y, z, v == n - 1);
        end
        @(posedge clk);
        i_vertex_valid <= 1'b0;
        i_vertex_last  <= 1'b0;
        while (fin_cnt == fin_before) @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // downstream receiver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin : credit_return
        if (!rstn) begin
            i_out_credit <= 1'b0;
            stall_left = 0;
        end else begin
            i_out_credit <= 1'b0;
            if (stall_left > 0) begin
                stall_left = stall_left - 1;
            end else if (stall_en && ($urandom % 32 == 0)) begin
                stall_left = 20 + $urandom % 40;        // long receiver stall
            end else if ((out_cnt > returned_cnt) && ($urandom % 3 == 0)) begin
                i_out_credit <= 1'b1;
                returned_cnt = returned_cnt + 1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output and credit checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk) begin : out_check
        logic [4*COORD_W-1:0] got_v;
        logic [4*COORD_W-1:0] exp_v;
        logic [4*COORD_W:0]   dir_v;
        if (rstn) begin
            if (o_in_credit) in_ret_cnt++;
            assert (IN_DEPTH - sent_cnt + in_ret_cnt >= 0 && in_ret_cnt <= sent_cnt) else begin
                other_err++;
                $display("upstream credit count left its range at %0t", $time);
            end
            assert (o_finished == fin_due) else report_mismatch("o_finished", fin_due, o_finished);
            fin_due = 1'b0;
            if (o_finished) begin
                fin_cnt++;
                out_in_batch = 0;
                assert (o_mvp_ready) else report_mismatch("o_mvp_ready", 1, o_mvp_ready);
            end
            if (o_vertex_valid) begin
                out_cnt++;
                out_in_batch++;
                fin_due = (out_in_batch == batch_len);     // last of the batch
                assert (out_cnt <= OUT_CREDITS + returned_cnt) else begin
                    other_err++;
                    $display("vertex sent downstream without a credit at %0t", $time);
                end
                if (exp_q.size() == 0) begin
                    other_err++;
                    $display("vertex came out at %0t with none expected", $time);
                end else begin
                    got_v = {o_vertex[3], o_vertex[2], o_vertex[1], o_vertex[0]};
                    exp_v = exp_q.pop_front();
                    dir_v = direct_q.pop_front();
                    assert (got_v == exp_v) else report_mismatch("o_vertex", exp_v, got_v);
                    if (dir_v[4*COORD_W]) begin
                        assert (got_v == dir_v[4*COORD_W-1:0]) else
                            report_mismatch("o_vertex", dir_v[4*COORD_W-1:0], got_v);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(WD_CYCLES * 8);
        $display("timeout: run did not complete within %0d cycles", WD_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin : main
        void'($urandom(98));
        rstn           = 1'b0;
        i_mvp_valid    = 1'b0;
        i_vertex_last  = 1'b0;
        i_vertex_valid = 1'b0;
        stall_en       = 1'b0;
        known_batch    = 1'b0;
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++) begin
                i_mvp[r][k] = '0;
            end
        end
        for (int k = 0; k < 3; k++) begin
            i_vertex[k] = '0;
            trans[k]    = '0;
        end

        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_idle_outputs();                           // right after release

        run_batch(0, 6);
        run_batch(1, 6);
        run_batch(2, 12);
        run_batch(2, 12);
        run_batch(3, 12);
        repeat (4) @(negedge clk);

        assert (exp_q.size() == 0) else begin
            other_err++;
            $display("%0d expected vertices never came out", exp_q.size());
        end
        assert (out_cnt == TOTAL_VTX) else report_mismatch("vertex count", TOTAL_VTX, out_cnt);
        assert (fin_cnt == BATCHES) else report_mismatch("o_finished count", BATCHES, fin_cnt);
        assert (in_ret_cnt == sent_cnt) else
            report_mismatch("upstream credits", IN_DEPTH, IN_DEPTH - sent_cnt + in_ret_cnt);

        $display("errors: %0d check failures, %0d other failures", chk_err, other_err);
        if (chk_err + other_err == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vertex_xform_top.f
+incdir+tests
source/vtx_pkg.sv
source/vertex_in_buffer.sv
source/matvec_mul.sv
source/vertex_shader.sv
source/vertex_xform_top.sv
tests/tb_vertex_xform.sv
